//--- hdl/nes_input_pkg.sv
package nes_input_pkg;

  // one player's buttons in the order the NES pad shifts them out
  // a leaves first, so it sits at bit 0
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } pad_bits_t;

  // turbo rate setting, phase toggles every speed+1 frames
  localparam int TURBO_SPEED_W = 3;

  // serial frame per controller port
  // own pad, then tap pad or fill, then signature or fill
  localparam int PORT_FRAME_BITS = 24;

  // Four Score signature bytes, shifted out after the second pad
  localparam logic [7:0] MULTITAP_SIG_PORT1 = 8'h08;
  localparam logic [7:0] MULTITAP_SIG_PORT2 = 8'h04;

  // reads past the first pad return ones without a multitap
  localparam logic [15:0] NO_MULTITAP_FILL = 16'hffff;

  // palette colour, red in the top byte
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pal_color_t;

  // 64 palette entries
  typedef logic [5:0] pal_index_t;

  // download bytes holding the palette, three per entry
  localparam int PALETTE_BYTES = 192;

endpackage

//--- hdl/pad_if.sv
`timescale 1ns/1ps

// eight merged buttons of one player
interface pad_if;

  logic a;
  logic b;
  logic select;
  logic start;
  logic up;
  logic down;
  logic left;
  logic right;

  // driven by the turbo and merge logic
  modport source (
    output a, b, select, start, up, down, left, right
  );

  // read by the controller ports
  modport sink (
    input a, b, select, start, up, down, left, right
  );

endinterface

//--- hdl/player_pad.sv
`timescale 1ns/1ps

module player_pad (
  input  logic                                     clk_ppu_21_47,
  input  logic                                     reset_nes,
  input  logic                                     vsync,
  input  logic [nes_input_pkg::TURBO_SPEED_W-1:0]  turbo_speed,
  input  nes_input_pkg::pad_bits_t                 buttons,
  input  logic                                     turbo_a,
  input  logic                                     turbo_b,
  pad_if.source                                    pad
);

  logic                                    vsync_q;
  logic                                    vsync_prev;
  logic                                    vsync_rise;
  logic [nes_input_pkg::TURBO_SPEED_W-1:0] frame_cnt;
  logic                                    phase;

  // sample vsync, then keep the previous sample for edge detection
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      vsync_q    <= 1'b0;
      vsync_prev <= 1'b0;
    end else begin
      vsync_q    <= vsync;
      vsync_prev <= vsync_q;
    end
  end

  assign vsync_rise = vsync_q & ~vsync_prev;

  // one frame per vsync, toggle phase when the count hits the speed
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      frame_cnt <= '0;
      phase     <= 1'b0;
    end else if (vsync_rise) begin
      if (frame_cnt == turbo_speed) begin
        frame_cnt <= '0;
        phase     <= ~phase;
      end else begin
        frame_cnt <= frame_cnt + 1'b1;
      end
    end
  end

  // merge held buttons with the turbo pulses
  assign pad.a      = buttons.a | (turbo_a & phase);
  assign pad.b      = buttons.b | (turbo_b & phase);
  assign pad.select = buttons.select;
  assign pad.start  = buttons.start;
  assign pad.up     = buttons.up;
  assign pad.down   = buttons.down;
  assign pad.left   = buttons.left;
  assign pad.right  = buttons.right;

endmodule

//--- hdl/joypad_port.sv
`timescale 1ns/1ps

module joypad_port #(
  parameter logic [7:0] multitap_sig = nes_input_pkg::MULTITAP_SIG_PORT1
) (
  input  logic   clk_ppu_21_47,
  input  logic   reset_nes,
  input  logic   strobe,
  input  logic   port_clock,
  input  logic   swap,
  input  logic   multitap,
  pad_if.sink    own_pad,
  pad_if.sink    swap_pad,
  pad_if.sink    tap_pad,
  output logic   data
);

  nes_input_pkg::pad_bits_t                  own_bits;
  nes_input_pkg::pad_bits_t                  swap_bits;
  nes_input_pkg::pad_bits_t                  tap_bits;
  logic [7:0]                                low_byte;
  logic [15:0]                               high_bits;
  logic [nes_input_pkg::PORT_FRAME_BITS-1:0] frame;
  logic                                      port_clock_q;

  // pack each pad back into shift order
  assign own_bits  = {own_pad.right, own_pad.left, own_pad.down, own_pad.up,
                      own_pad.start, own_pad.select, own_pad.b, own_pad.a};
  assign swap_bits = {swap_pad.right, swap_pad.left, swap_pad.down, swap_pad.up,
                      swap_pad.start, swap_pad.select, swap_pad.b, swap_pad.a};
  assign tap_bits  = {tap_pad.right, tap_pad.left, tap_pad.down, tap_pad.up,
                      tap_pad.start, tap_pad.select, tap_pad.b, tap_pad.a};

  assign low_byte  = swap ? swap_bits : own_bits;
  assign high_bits = multitap ? {multitap_sig, tap_bits} : nes_input_pkg::NO_MULTITAP_FILL;

  // strobe level reloads, falling port clock shifts toward bit 0
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      frame        <= '0;
      port_clock_q <= 1'b0;
    end else begin
      port_clock_q <= port_clock;
      if (strobe) begin
        frame <= {high_bits, low_byte};
      end else if (port_clock_q && !port_clock) begin
        frame <= {1'b0, frame[nes_input_pkg::PORT_FRAME_BITS-1:1]};
      end
    end
  end

  assign data = frame[0];

endmodule

//--- hdl/palette_loader.sv
`timescale 1ns/1ps

module palette_loader (
  input  logic                      clk_ppu_21_47,
  input  logic                      reset_nes,
  input  logic                      palette_download,
  input  logic                      byte_write,
  input  logic [7:0]                byte_addr,
  input  logic [7:0]                byte_data,
  output logic                      color_write,
  output nes_input_pkg::pal_color_t color,
  output nes_input_pkg::pal_index_t color_index
);

  logic [1:0] byte_cnt;
  logic       byte_ok;

  // only bytes inside the palette area count
  assign byte_ok = palette_download && byte_write &&
                   (byte_addr < 8'(nes_input_pkg::PALETTE_BYTES));

  // byte position within the triple and the entry number
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes || !palette_download) begin
      byte_cnt    <= 2'd0;
      color_index <= '0;
    end else if (byte_ok) begin
      byte_cnt <= (byte_cnt == 2'd2) ? 2'd0 : byte_cnt + 2'd1;
      // first byte of a new triple moves to the next entry
      if (byte_cnt == 2'd0 && byte_addr != 8'd0) begin
        color_index <= color_index + 1'b1;
      end
    end
  end

  // colour channels in red, green, blue order
  always_ff @(posedge clk_ppu_21_47) begin
    if (byte_ok) begin
      case (byte_cnt)
        2'd0:    color.r <= byte_data;
        2'd1:    color.g <= byte_data;
        2'd2:    color.b <= byte_data;
        default: ;
      endcase
    end
  end

  // a full triple is ready whenever the count wraps back to 0
  assign color_write = palette_download && (byte_cnt == 2'd0);

endmodule

//--- hdl/nes_input_top.sv
`timescale 1ns/1ps

module nes_input_top (
  input  logic                                    clk_ppu_21_47,
  input  logic                                    reset_nes,
  input  logic                                    vsync,
  input  logic [nes_input_pkg::TURBO_SPEED_W-1:0] turbo_speed,

  input  nes_input_pkg::pad_bits_t                p1_buttons,
  input  logic                                    p1_turbo_a,
  input  logic                                    p1_turbo_b,
  input  nes_input_pkg::pad_bits_t                p2_buttons,
  input  logic                                    p2_turbo_a,
  input  logic                                    p2_turbo_b,
  input  nes_input_pkg::pad_bits_t                p3_buttons,
  input  logic                                    p3_turbo_a,
  input  logic                                    p3_turbo_b,
  input  nes_input_pkg::pad_bits_t                p4_buttons,
  input  logic                                    p4_turbo_a,
  input  logic                                    p4_turbo_b,

  input  logic                                    swap_controllers,
  input  logic                                    multitap_enabled,
  input  logic                                    joypad_strobe,
  input  logic                                    joypad_clock1,
  input  logic                                    joypad_clock2,

  input  logic                                    palette_download,
  input  logic                                    ioctl_wr,
  input  logic [7:0]                              ioctl_addr,
  input  logic [7:0]                              ioctl_dout,

  output logic                                    joypad1_data,
  output logic                                    joypad2_data,
  output logic                                    palette_write_en,
  output nes_input_pkg::pal_color_t               palette_color,
  output nes_input_pkg::pal_index_t               palette_index
);

  // merged pads of players 1 to 4
  pad_if pad_a ();
  pad_if pad_b ();
  pad_if pad_c ();
  pad_if pad_d ();

  player_pad p1_pad_i (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .vsync         (vsync),
    .turbo_speed   (turbo_speed),
    .buttons       (p1_buttons),
    .turbo_a       (p1_turbo_a),
    .turbo_b       (p1_turbo_b),
    .pad           (pad_a.source)
  );

  player_pad p2_pad_i (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .vsync         (vsync),
    .turbo_speed   (turbo_speed),
    .buttons       (p2_buttons),
    .turbo_a       (p2_turbo_a),
    .turbo_b       (p2_turbo_b),
    .pad           (pad_b.source)
  );

  player_pad p3_pad_i (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .vsync         (vsync),
    .turbo_speed   (turbo_speed),
    .buttons       (p3_buttons),
    .turbo_a       (p3_turbo_a),
    .turbo_b       (p3_turbo_b),
    .pad           (pad_c.source)
  );

  player_pad p4_pad_i (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .vsync         (vsync),
    .turbo_speed   (turbo_speed),
    .buttons       (p4_buttons),
    .turbo_a       (p4_turbo_a),
    .turbo_b       (p4_turbo_b),
    .pad           (pad_d.source)
  );

  // port 1 reads A, swaps to B, taps C
  joypad_port #(
    .multitap_sig (nes_input_pkg::MULTITAP_SIG_PORT1)
  ) port1_i (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .strobe        (joypad_strobe),
    .port_clock    (joypad_clock1),
    .swap          (swap_controllers),
    .multitap      (multitap_enabled),
    .own_pad       (pad_a.sink),
    .swap_pad      (pad_b.sink),
    .tap_pad       (pad_c.sink),
    .data          (joypad1_data)
  );

  // port 2 reads B, swaps to A, taps D
  joypad_port #(
    .multitap_sig (nes_input_pkg::MULTITAP_SIG_PORT2)
  ) port2_i (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .strobe        (joypad_strobe),
    .port_clock    (joypad_clock2),
    .swap          (swap_controllers),
    .multitap      (multitap_enabled),
    .own_pad       (pad_b.sink),
    .swap_pad      (pad_a.sink),
    .tap_pad       (pad_d.sink),
    .data          (joypad2_data)
  );

  palette_loader palette_i (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .palette_download (palette_download),
    .byte_write       (ioctl_wr),
    .byte_addr        (ioctl_addr),
    .byte_data        (ioctl_dout),
    .color_write      (palette_write_en),
    .color            (palette_color),
    .color_index      (palette_index)
  );

endmodule

//--- tb/tb_model.svh
// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// expected serial frame of one port, bit 0 shifts out first
function automatic logic [23:0] port_frame(input logic [7:0] own, input logic [7:0] other,
                                           input logic [7:0] tap, input logic swap_en,
                                           input logic tap_en, input logic [7:0] sig);
  logic [7:0]  low;
  logic [15:0] high;
  low  = swap_en ? other : own;
  high = tap_en ? {sig, tap} : 16'hffff;
  return {high, low};
endfunction

// phase after a number of vsync edges from reset, toggles every speed+1 frames
function automatic logic turbo_phase(input int edges, input logic [2:0] speed);
  return ((edges / (int'(speed) + 1)) % 2) == 1;
endfunction

// colour of one downloaded triple, red first
function automatic logic [23:0] expected_color(input logic [7:0] r, input logic [7:0] g,
                                               input logic [7:0] b);
  return {r, g, b};
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (actual !== expected) begin
    $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    $display("Simulation failed");
    $fatal(1, "mismatch in test %s", name);
  end
endtask

//--- tb/tb_nes_input.sv
`timescale 1ns/1ps

module tb_nes_input;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int N_PLAIN      = 8;
  localparam int N_SWAP       = 4;
  localparam int N_TAP        = 4;
  localparam int N_TURBO      = 6;
  localparam int VSYNC_MAX    = 20;
  localparam int VSYNC_GAP    = 6;
  localparam int PAL_BYTES    = 192;
  localparam int N_PAL_EXTRA  = 8;
  localparam int READ_CYCLES  = 4 + 3 * 24;
  localparam int TURBO_CYCLES = 1 + RESET_CYCLES + VSYNC_MAX * VSYNC_GAP + READ_CYCLES;
  localparam int PAL_CYCLES   = 2 * (PAL_BYTES + N_PAL_EXTRA) + 4;
  localparam int TEST_CYCLES  = (N_PLAIN + N_SWAP + N_TAP) * READ_CYCLES
                                + N_TURBO * TURBO_CYCLES + PAL_CYCLES;

  logic                      clk_ppu_21_47 = 1'b0;
  logic                      reset_nes;
  logic                      vsync;
  logic [2:0]                turbo_speed;
  nes_input_pkg::pad_bits_t  p1_buttons;
  nes_input_pkg::pad_bits_t  p2_buttons;
  nes_input_pkg::pad_bits_t  p3_buttons;
  nes_input_pkg::pad_bits_t  p4_buttons;
  logic                      p1_turbo_a;
  logic                      p1_turbo_b;
  logic                      p2_turbo_a;
  logic                      p2_turbo_b;
  logic                      p3_turbo_a;
  logic                      p3_turbo_b;
  logic                      p4_turbo_a;
  logic                      p4_turbo_b;
  logic                      swap_controllers;
  logic                      multitap_enabled;
  logic                      joypad_strobe;
  logic                      joypad_clock1;
  logic                      joypad_clock2;
  logic                      palette_download;
  logic                      ioctl_wr;
  logic [7:0]                ioctl_addr;
  logic [7:0]                ioctl_dout;
  logic                      joypad1_data;
  logic                      joypad2_data;
  logic                      palette_write_en;
  nes_input_pkg::pal_color_t palette_color;
  nes_input_pkg::pal_index_t palette_index;

  // expectation handed to the compare process
  logic        cmp_en;
  logic        cmp_kind;
  logic [31:0] cmp_exp;
  string       test_name;
  logic [31:0] rng_state;

  `include "tb_model.svh"

  always #(CLK_PERIOD / 2) clk_ppu_21_47 = ~clk_ppu_21_47;

  nes_input_top nes_input_top_i (.*);

  // compare in the middle of the cycle, away from the driving edge
  always @(negedge clk_ppu_21_47) begin
    if (cmp_en) begin
      if (cmp_kind) begin
        check_value(test_name, cmp_exp,
                    {1'b0, palette_write_en, palette_index, palette_color});
      end else begin
        check_value(test_name, cmp_exp, {30'd0, joypad1_data, joypad2_data});
      end
    end
  end

  initial begin
    #((TEST_CYCLES * 2 + RESET_CYCLES) * CLK_PERIOD);
    $display("watchdog expired while running test %s", test_name);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  task automatic apply_reset();
    reset_nes <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_ppu_21_47);
    reset_nes <= 1'b0;
  endtask

  // strobe both ports, then clock out all 24 bits plus one
  task automatic read_frames(input logic [23:0] f1, input logic [23:0] f2);
    logic [24:0] e1;
    logic [24:0] e2;
    int          i;
    e1 = {1'b0, f1};
    e2 = {1'b0, f2};
    @(posedge clk_ppu_21_47);
    joypad_strobe <= 1'b1;
    @(posedge clk_ppu_21_47);
    joypad_strobe <= 1'b0;
    cmp_kind      <= 1'b0;
    cmp_exp       <= {30'd0, e1[0], e2[0]};
    cmp_en        <= 1'b1;
    for (i = 0; i < 24; i++) begin
      @(posedge clk_ppu_21_47);
      cmp_en        <= 1'b0;
      joypad_clock1 <= 1'b1;
      joypad_clock2 <= 1'b1;
      @(posedge clk_ppu_21_47);
      joypad_clock1 <= 1'b0;
      joypad_clock2 <= 1'b0;
      // falling clock seen on this edge, frame shifts
      @(posedge clk_ppu_21_47);
      cmp_exp <= {30'd0, e1[i+1], e2[i+1]};
      cmp_en  <= 1'b1;
    end
    @(posedge clk_ppu_21_47);
    cmp_en <= 1'b0;
  endtask

  task automatic run_readout(input string name, input logic swap_en, input logic tap_en,
                             input int count);
    logic [7:0] pad_a;
    logic [7:0] pad_b;
    logic [7:0] pad_c;
    logic [7:0] pad_d;
    int         n;
    test_name = name;
    for (n = 0; n < count; n++) begin
      rng_state = xorshift32(rng_state);
      pad_a     = rng_state[7:0];
      pad_b     = rng_state[15:8];
      pad_c     = rng_state[23:16];
      pad_d     = rng_state[31:24];
      @(posedge clk_ppu_21_47);
      p1_buttons       <= nes_input_pkg::pad_bits_t'(pad_a);
      p2_buttons       <= nes_input_pkg::pad_bits_t'(pad_b);
      p3_buttons       <= nes_input_pkg::pad_bits_t'(pad_c);
      p4_buttons       <= nes_input_pkg::pad_bits_t'(pad_d);
      swap_controllers <= swap_en;
      multitap_enabled <= tap_en;
      read_frames(port_frame(pad_a, pad_b, pad_c, swap_en, tap_en, 8'h08),
                  port_frame(pad_b, pad_a, pad_d, swap_en, tap_en, 8'h04));
    end
  endtask

  // only player 1 turbo a held, phase shows up as bit 0 of port 1
  task automatic run_turbo(input int rounds);
    logic [2:0] speed;
    logic       phase;
    int         pulses;
    int         r;
    int         k;
    test_name = "turbo";
    for (r = 0; r < rounds; r++) begin
      rng_state = xorshift32(rng_state);
      speed     = rng_state[2:0];
      pulses    = 1 + int'(rng_state[12:8]) % VSYNC_MAX;
      @(posedge clk_ppu_21_47);
      turbo_speed      <= speed;
      p1_buttons       <= '0;
      p2_buttons       <= '0;
      p3_buttons       <= '0;
      p4_buttons       <= '0;
      p1_turbo_a       <= 1'b1;
      swap_controllers <= 1'b0;
      multitap_enabled <= 1'b0;
      apply_reset();
      for (k = 0; k < pulses; k++) begin
        vsync <= 1'b1;
        repeat (VSYNC_GAP / 2) @(posedge clk_ppu_21_47);
        vsync <= 1'b0;
        repeat (VSYNC_GAP / 2) @(posedge clk_ppu_21_47);
      end
      phase = turbo_phase(pulses, speed);
      read_frames(port_frame({7'd0, phase}, 8'd0, 8'd0, 1'b0, 1'b0, 8'h08),
                  port_frame(8'd0, {7'd0, phase}, 8'd0, 1'b0, 1'b0, 8'h04));
    end
    p1_turbo_a <= 1'b0;
  endtask

  task automatic run_palette();
    logic [7:0] pal_bytes [0:PAL_BYTES-1];
    logic [7:0] data;
    int         a;
    int         t;
    test_name = "palette";
    @(posedge clk_ppu_21_47);
    palette_download <= 1'b1;
    for (a = 0; a < PAL_BYTES + N_PAL_EXTRA; a++) begin
      rng_state = xorshift32(rng_state);
      data      = rng_state[7:0];
      if (a < PAL_BYTES) begin
        pal_bytes[a] = data;
      end
      @(posedge clk_ppu_21_47);
      cmp_en     <= 1'b0;
      ioctl_wr   <= 1'b1;
      ioctl_addr <= 8'(a);
      ioctl_dout <= data;
      @(posedge clk_ppu_21_47);
      ioctl_wr <= 1'b0;
      // bytes past the palette must leave the last entry in place
      if (a >= PAL_BYTES || a % 3 == 2) begin
        t = (a < PAL_BYTES) ? a / 3 : PAL_BYTES / 3 - 1;
        cmp_kind <= 1'b1;
        cmp_exp  <= {1'b0, 1'b1, 6'(t),
                     expected_color(pal_bytes[3*t], pal_bytes[3*t+1], pal_bytes[3*t+2])};
        cmp_en   <= 1'b1;
      end
    end
    @(posedge clk_ppu_21_47);
    cmp_en           <= 1'b0;
    palette_download <= 1'b0;
  endtask

  initial begin
    reset_nes        = 1'b1;
    vsync            = 1'b0;
    turbo_speed      = '0;
    p1_buttons       = '0;
    p2_buttons       = '0;
    p3_buttons       = '0;
    p4_buttons       = '0;
    p1_turbo_a       = 1'b0;
    p1_turbo_b       = 1'b0;
    p2_turbo_a       = 1'b0;
    p2_turbo_b       = 1'b0;
    p3_turbo_a       = 1'b0;
    p3_turbo_b       = 1'b0;
    p4_turbo_a       = 1'b0;
    p4_turbo_b       = 1'b0;
    swap_controllers = 1'b0;
    multitap_enabled = 1'b0;
    joypad_strobe    = 1'b0;
    joypad_clock1    = 1'b0;
    joypad_clock2    = 1'b0;
    palette_download = 1'b0;
    ioctl_wr         = 1'b0;
    ioctl_addr       = '0;
    ioctl_dout       = '0;
    cmp_en           = 1'b0;
    cmp_kind         = 1'b0;
    cmp_exp          = '0;
    test_name        = "reset";
    rng_state        = 32'h64027ac1;
    apply_reset();
    run_readout("plain", 1'b0, 1'b0, N_PLAIN);
    run_readout("swap", 1'b1, 1'b0, N_SWAP);
    run_readout("multitap", 1'b0, 1'b1, N_TAP);
    run_turbo(N_TURBO);
    run_palette();
    repeat (4) @(posedge clk_ppu_21_47);
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+tb
hdl/nes_input_pkg.sv
hdl/pad_if.sv
hdl/player_pad.sv
hdl/joypad_port.sv
hdl/palette_loader.sv
hdl/nes_input_top.sv
tb/tb_nes_input.sv

//--- Makefile
TOP := tb_nes_input

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
